// File: hw/background_shifter.sv
module background_shifter (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 active,
    input  ppu_pkg::hcount_t     hcount,
    output ppu_pkg::tile_col_t   rd_col,
    input  ppu_pkg::line_entry_t rd_entry,
    output ppu_pkg::pixel_code_t pixel
);
    import ppu_pkg::*;

    tile_row_t shift_q;  // Remaining pixels of the current tile, lowest first
    logic      pal_q;    // Palette bit of the current tile

    assign rd_col = tile_col_t'(hcount / TILE_PIXELS);

    always_ff @(posedge clk) begin
        if (reset) begin
            shift_q <= '0;
            pal_q   <= 1'b0;
        end else if (active) begin
            if (hcount % TILE_PIXELS == 0) begin
                shift_q <= rd_entry.row;      // Tile boundary
                pal_q   <= rd_entry.palette;
            end else begin
                shift_q <= shift_q >> 2;      // Next 2-bit pixel
            end
        end
    end

    assign pixel = '{palette: pal_q, code: shift_q[1:0]};

endmodule

// File: hw/line_buffer.sv
module line_buffer (
    input  logic                 clk,
    input  logic                 wr_en,
    input  ppu_pkg::tile_col_t   wr_col,
    input  ppu_pkg::line_entry_t wr_entry,
    input  ppu_pkg::tile_col_t   rd_col,
    output ppu_pkg::line_entry_t rd_entry
);
    import ppu_pkg::*;

    // One graphics row and palette bit per tile of the current line
    line_entry_t entries [TILES_PER_LINE];

    always_ff @(posedge clk) begin
        if (wr_en)
            entries[wr_col] <= wr_entry;
    end

    // Shifter sees the entry in the same cycle
    assign rd_entry = entries[rd_col];

endmodule

// File: hw/palette_cache.sv
module palette_cache (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 vblank,
    input  logic                 hsync,
    input  ppu_pkg::pixel_code_t pixel,
    input  ppu_pkg::color_t      pal_data,
    output logic                 pal_en,
    output ppu_pkg::pal_addr_t   pal_addr,
    output ppu_pkg::color_t      pixel_color
);
    import ppu_pkg::*;

    color_t     colors [PALETTE_ENTRIES];  // Local copy of the palette memory
    logic [3:0] load_ptr;                  // Steps through issue, store and idle

    // Read issue while vblank is high, one address per cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            load_ptr <= '0;
            pal_en   <= 1'b0;
            pal_addr <= '0;
        end else if (vblank) begin
            if (load_ptr < PALETTE_ENTRIES) begin
                pal_en   <= 1'b1;
                pal_addr <= pal_addr_t'(load_ptr);
            end else begin
                pal_en <= 1'b0;  // All reads issued
            end
            if (load_ptr < PALETTE_ENTRIES + 2)
                load_ptr <= load_ptr + 4'd1;
        end else begin
            load_ptr <= '0;  // Next blank reloads everything
            pal_en   <= 1'b0;
        end
    end

    // Data for the address issued two steps back arrives now
    always_ff @(posedge clk) begin
        if (!reset && vblank && load_ptr >= 2 && load_ptr < PALETTE_ENTRIES + 2)
            colors[pal_addr_t'(load_ptr - 4'd2)] <= pal_data;
    end

    // Colour lookup during active video
    always_ff @(posedge clk) begin
        if (reset)
            pixel_color <= '0;
        else if (!vblank && !hsync)
            pixel_color <= colors[pal_addr_t'(pixel)];
    end

endmodule

// File: hw/ppu_pkg.sv
package ppu_pkg;

    // Screen and tile geometry
    localparam int TILES_PER_LINE    = 40;
    localparam int TILE_PIXELS       = 16;  // Tile width and height
    localparam int ENTRIES_PER_WORD  = 4;   // Tile-map entries per 32-bit word
    localparam int MAP_WORDS_PER_ROW = 10;
    localparam int PALETTE_ENTRIES   = 8;

    // Counter and address widths
    typedef logic [10:0] hcount_t;
    typedef logic [9:0]  vcount_t;
    typedef logic [8:0]  map_addr_t;   // Tile-map memory
    typedef logic [10:0] gfx_addr_t;   // Tile graphics memory
    typedef logic [2:0]  pal_addr_t;   // Colour palette memory
    typedef logic [5:0]  tile_col_t;   // Tile column within a line
    typedef logic [23:0] color_t;

    // One tile-map entry
    typedef struct packed {
        logic       palette;
        logic [6:0] tile_id;
    } tile_entry_t;

    // Entry k sits in bits 8k+7:8k
    typedef tile_entry_t [ENTRIES_PER_WORD-1:0] map_word_t;

    // One graphics row, pixel i in bits 2i+1:2i
    typedef logic [31:0] tile_row_t;

    // Inputs from the VGA controller
    typedef struct packed {
        hcount_t hcount;
        vcount_t vcount;
        logic    vblank;
        logic    hsync;
    } video_timing_t;

    // Line buffer contents per tile
    typedef struct packed {
        logic      palette;
        tile_row_t row;
    } line_entry_t;

    // Palette bit on top, so the whole value is a palette address
    typedef struct packed {
        logic       palette;
        logic [1:0] code;
    } pixel_code_t;

endpackage

// File: hw/ppu_top.sv
module ppu_top (
    input  logic                   clk,
    input  logic                   reset,
    input  ppu_pkg::video_timing_t timing,
    input  ppu_pkg::map_word_t     map_data,
    input  ppu_pkg::tile_row_t     gfx_data,
    input  ppu_pkg::color_t        pal_data,
    output logic                   map_en,
    output logic                   gfx_en,
    output logic                   pal_en,
    output ppu_pkg::map_addr_t     map_addr,
    output ppu_pkg::gfx_addr_t     gfx_addr,
    output ppu_pkg::pal_addr_t     pal_addr,
    output ppu_pkg::color_t        pixel_color
);
    import ppu_pkg::*;

    logic        active;    // Neither blanking nor sync
    logic        wr_en;
    tile_col_t   wr_col;
    line_entry_t wr_entry;
    tile_col_t   rd_col;
    line_entry_t rd_entry;
    pixel_code_t pixel;

    assign active = !timing.vblank && !timing.hsync;

    // Palette copy in vblank, colour lookup in active video
    palette_cache u_palette_cache (
        .clk         (clk),
        .reset       (reset),
        .vblank      (timing.vblank),
        .hsync       (timing.hsync),
        .pixel       (pixel),
        .pal_data    (pal_data),
        .pal_en      (pal_en),
        .pal_addr    (pal_addr),
        .pixel_color (pixel_color)
    );

    // Fetches the next line during hsync
    tile_line_fetch u_tile_line_fetch (
        .clk      (clk),
        .reset    (reset),
        .hsync    (timing.hsync),
        .vblank   (timing.vblank),
        .vcount   (timing.vcount),
        .map_data (map_data),
        .gfx_data (gfx_data),
        .map_en   (map_en),
        .gfx_en   (gfx_en),
        .map_addr (map_addr),
        .gfx_addr (gfx_addr),
        .wr_en    (wr_en),
        .wr_col   (wr_col),
        .wr_entry (wr_entry)
    );

    line_buffer u_line_buffer (
        .clk      (clk),
        .wr_en    (wr_en),
        .wr_col   (wr_col),
        .wr_entry (wr_entry),
        .rd_col   (rd_col),
        .rd_entry (rd_entry)
    );

    background_shifter u_background_shifter (
        .clk      (clk),
        .reset    (reset),
        .active   (active),
        .hcount   (timing.hcount),
        .rd_col   (rd_col),
        .rd_entry (rd_entry),
        .pixel    (pixel)
    );

endmodule

// File: hw/tile_line_fetch.sv
module tile_line_fetch (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 hsync,
    input  logic                 vblank,
    input  ppu_pkg::vcount_t     vcount,
    input  ppu_pkg::map_word_t   map_data,
    input  ppu_pkg::tile_row_t   gfx_data,
    output logic                 map_en,
    output logic                 gfx_en,
    output ppu_pkg::map_addr_t   map_addr,
    output ppu_pkg::gfx_addr_t   gfx_addr,
    output logic                 wr_en,
    output ppu_pkg::tile_col_t   wr_col,
    output ppu_pkg::line_entry_t wr_entry
);
    import ppu_pkg::*;

    logic [5:0]  step;        // Cycles since hsync rose
    logic [5:0]  tile_row;    // Tile-map row for this line
    logic [3:0]  tile_line;   // Line within the tile
    tile_col_t   issue_col;   // Tile whose graphics read goes out now
    logic [1:0]  slot;        // Position of that tile in its map word
    logic        issue_map;
    logic        issue_gfx;
    map_word_t   hold_word;   // Map word whose later entries still wait
    tile_entry_t entry;

    // Request pipeline, one stage per memory cycle
    tile_col_t   col_q;
    logic        pal_q;
    tile_col_t   col_d;
    logic        pal_d;
    logic        gfx_vld;

    assign tile_row  = 6'(vcount / TILE_PIXELS);
    assign tile_line = 4'(vcount % TILE_PIXELS);

    // Map word w goes out at step 4w and lands at step 4w+2
    assign issue_col = step - 6'd2;
    assign slot      = 2'(issue_col % ENTRIES_PER_WORD);
    assign issue_map = (step < TILES_PER_LINE) && (step % ENTRIES_PER_WORD == 0);
    assign issue_gfx = (step >= 2) && (step < TILES_PER_LINE + 2);

    // First entry straight from the memory, the rest from the holding word
    assign entry = (slot == 2'd0) ? map_data[0] : hold_word[slot];

    always_ff @(posedge clk) begin
        if (reset) begin
            step    <= '0;
            map_en  <= 1'b0;
            gfx_en  <= 1'b0;
            gfx_vld <= 1'b0;
        end else begin
            gfx_vld <= gfx_en;  // Row comes back one cycle after the read
            if (hsync && !vblank) begin
                map_en <= issue_map;
                gfx_en <= issue_gfx;
                if (step < TILES_PER_LINE + 2)
                    step <= step + 6'd1;
            end else begin
                step   <= '0;
                map_en <= 1'b0;
                gfx_en <= 1'b0;
            end
        end
    end

    // Addresses matter only in enabled cycles
    always_ff @(posedge clk) begin
        map_addr <= map_addr_t'(tile_row) * map_addr_t'(MAP_WORDS_PER_ROW)
                    + map_addr_t'(step / ENTRIES_PER_WORD);
        gfx_addr <= gfx_addr_t'(entry.tile_id) * gfx_addr_t'(TILE_PIXELS)
                    + gfx_addr_t'(tile_line);
        if (issue_gfx && slot == 2'd0)
            hold_word <= map_data;
        col_q <= issue_col;
        pal_q <= entry.palette;
        col_d <= col_q;
        pal_d <= pal_q;
    end

    // Returning row goes straight into the line buffer
    assign wr_en    = gfx_vld;
    assign wr_col   = col_d;
    assign wr_entry = '{palette: pal_d, row: gfx_data};

endmodule

// File: run.sh
#!/bin/sh
# Build and run the PPU background testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal \
    --top-module tb_ppu_top \
    -f vlog.f \
    -o tb_ppu_top

./obj_dir/tb_ppu_top > sim.log 2>&1
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
    echo "Simulation reported failure, see sim.log"
    exit 1
fi

echo "Simulation finished without failure"

// File: verif/ppu_mem_model.sv
module ppu_mem_model (
    input  logic               clk,
    input  logic               map_en,
    input  ppu_pkg::map_addr_t map_addr,
    output ppu_pkg::map_word_t map_data,
    input  logic               gfx_en,
    input  ppu_pkg::gfx_addr_t gfx_addr,
    output ppu_pkg::tile_row_t gfx_data,
    input  logic               pal_en,
    input  ppu_pkg::pal_addr_t pal_addr,
    output ppu_pkg::color_t    pal_data
);
    import ppu_pkg::*;

    // Contents are written directly by the testbench
    map_word_t map_mem [2**$bits(map_addr_t)];
    tile_row_t gfx_mem [2**$bits(gfx_addr_t)];
    color_t    pal_mem [PALETTE_ENTRIES];

    // One-cycle read latency, data holds until the next enabled read
    always @(posedge clk) begin
        if (map_en)
            map_data <= map_mem[map_addr];
        if (gfx_en)
            gfx_data <= gfx_mem[gfx_addr];
        if (pal_en)
            pal_data <= pal_mem[pal_addr];
    end

endmodule

// File: verif/tb_ppu_top.sv
module tb_ppu_top;
    import ppu_pkg::*;

    localparam int CLK_PERIOD    = 40;
    localparam int RESET_CYCLES  = 8;
    localparam int IDLE_CYCLES   = 8;
    localparam int VBLANK_CYCLES = 12;
    localparam int HSYNC_CYCLES  = 45;
    localparam int ACTIVE_PIXELS = 640;
    localparam int PORCH_CYCLES  = 4;   // Front porch lets the last pixel leave the pipeline
    localparam int LINE_CYCLES   = HSYNC_CYCLES + ACTIVE_PIXELS + PORCH_CYCLES;
    localparam int TEST_LINES    = 6;
    localparam int RUN_CYCLES    = RESET_CYCLES + IDLE_CYCLES + 2 * VBLANK_CYCLES
                                   + TEST_LINES * LINE_CYCLES;
    localparam int WATCHDOG_TIME = (RUN_CYCLES + 200) * CLK_PERIOD;

    logic          clk = 1'b0;
    logic          reset;
    video_timing_t timing;
    map_word_t     map_data;
    tile_row_t     gfx_data;
    color_t        pal_data;
    logic          map_en;
    logic          gfx_en;
    logic          pal_en;
    map_addr_t     map_addr;
    gfx_addr_t     gfx_addr;
    pal_addr_t     pal_addr;
    color_t        pixel_color;

    logic [15:0] lfsr_state;
    color_t      used_colors [$];  // Every palette colour written so far
    int          errors;
    int          checks;
    int          lower_hits;       // Pixels shown in palette entries 0 to 3
    int          upper_hits;
    string       test_name;
    logic        pixel_check;      // Set once a palette has been loaded

    // Timing seen by the DUT, delayed to line up with pixel_color
    logic    s1_idle;
    logic    s1_pixel;
    logic    s2_pixel;
    vcount_t s1_v;
    vcount_t s2_v;
    hcount_t s1_h;
    hcount_t s2_h;

    always #(CLK_PERIOD / 2) clk = ~clk;

    ppu_top uut (
        .clk         (clk),
        .reset       (reset),
        .timing      (timing),
        .map_data    (map_data),
        .gfx_data    (gfx_data),
        .pal_data    (pal_data),
        .map_en      (map_en),
        .gfx_en      (gfx_en),
        .pal_en      (pal_en),
        .map_addr    (map_addr),
        .gfx_addr    (gfx_addr),
        .pal_addr    (pal_addr),
        .pixel_color (pixel_color)
    );

    ppu_mem_model mem (
        .clk      (clk),
        .map_en   (map_en),
        .map_addr (map_addr),
        .map_data (map_data),
        .gfx_en   (gfx_en),
        .gfx_addr (gfx_addr),
        .gfx_data (gfx_data),
        .pal_en   (pal_en),
        .pal_addr (pal_addr),
        .pal_data (pal_data)
    );

    // 16-bit Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
    endfunction

    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        int          i;
        value = '0;
        for (i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);  // One step per bit
            value      = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    // Palette address for pixel h of line v, built from the memory contents
    function automatic pal_addr_t ref_pal_index(input int v, input int h);
        map_word_t   word;
        tile_entry_t entry;
        tile_row_t   row;
        int          pix;
        word  = mem.map_mem[(v / TILE_PIXELS) * MAP_WORDS_PER_ROW
                            + h / (TILE_PIXELS * ENTRIES_PER_WORD)];
        entry = word[(h / TILE_PIXELS) % ENTRIES_PER_WORD];
        row   = mem.gfx_mem[int'(entry.tile_id) * TILE_PIXELS + v % TILE_PIXELS];
        pix   = h % TILE_PIXELS;
        return {entry.palette, row[2 * pix +: 2]};
    endfunction

    function automatic color_t ref_color(input int v, input int h);
        return mem.pal_mem[ref_pal_index(v, h)];
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic fill_memories();
        int i;
        for (i = 0; i < 2**$bits(map_addr_t); i++)
            mem.map_mem[i] = random_bits(32);
        for (i = 0; i < 2**$bits(gfx_addr_t); i++)
            mem.gfx_mem[i] = random_bits(32);
    endtask

    // Even tiles use the lower palette half, odd tiles the upper
    task automatic alternate_palette_bits(input int tile_row);
        int        col;
        int        addr;
        map_word_t word;
        for (col = 0; col < TILES_PER_LINE; col++) begin
            addr = tile_row * MAP_WORDS_PER_ROW + col / ENTRIES_PER_WORD;
            word = mem.map_mem[addr];
            word[col % ENTRIES_PER_WORD].palette = col[0];
            mem.map_mem[addr] = word;
        end
    endtask

    // New colours never repeat an earlier one
    task automatic load_palette();
        int     i;
        int     j;
        color_t color;
        logic   repeated;
        for (i = 0; i < PALETTE_ENTRIES; i++) begin
            do begin
                color    = color_t'(random_bits(24));
                repeated = 1'b0;
                for (j = 0; j < used_colors.size(); j++) begin
                    if (used_colors[j] == color)
                        repeated = 1'b1;
                end
            end while (repeated);
            used_colors.push_back(color);
            mem.pal_mem[i] = color;
        end
    endtask

    task automatic drive_timing(input logic blank, input logic sync, input int v, input int h);
        @(negedge clk);
        timing.vblank = blank;
        timing.hsync  = sync;
        timing.vcount = vcount_t'(v);
        timing.hcount = hcount_t'(h);
    endtask

    task automatic run_vblank();
        repeat (VBLANK_CYCLES) drive_timing(1'b1, 1'b0, 0, 0);
    endtask

    task automatic run_line(input int v, input string name);
        int h;
        test_name = name;
        for (h = 0; h < HSYNC_CYCLES; h++)
            drive_timing(1'b0, 1'b1, v, 0);
        for (h = 0; h < ACTIVE_PIXELS + PORCH_CYCLES; h++)
            drive_timing(1'b0, 1'b0, v, h);
    endtask

    always @(posedge clk) begin
        s1_idle  <= !reset && !timing.vblank && !timing.hsync;
        s1_pixel <= !reset && pixel_check && !timing.vblank && !timing.hsync
                    && (int'(timing.hcount) < ACTIVE_PIXELS);
        s1_v     <= timing.vcount;
        s1_h     <= timing.hcount;
        s2_pixel <= s1_pixel;
        s2_v     <= s1_v;
        s2_h     <= s1_h;
    end

    always @(negedge clk) begin : compare
        int i;
        if (s1_idle) begin  // Edge after idle timing has passed
            check("map_en low outside blank and sync", 0, 32'(map_en));
            check("gfx_en low outside blank and sync", 0, 32'(gfx_en));
            check("pal_en low outside blank and sync", 0, 32'(pal_en));
        end
        if (s2_pixel) begin
            // Palette half of the colour the DUT actually shows
            for (i = 0; i < PALETTE_ENTRIES; i++) begin
                if (pixel_color == mem.pal_mem[i]) begin
                    if (i >= PALETTE_ENTRIES / 2)
                        upper_hits++;
                    else
                        lower_hits++;
                end
            end
            check($sformatf("%s v=%0d h=%0d", test_name, s2_v, s2_h),
                  32'(ref_color(int'(s2_v), int'(s2_h))), 32'(pixel_color));
        end
    end

    initial begin
        reset       = 1'b1;
        timing      = '0;
        pixel_check = 1'b0;
        errors      = 0;
        checks      = 0;
        lower_hits  = 0;
        upper_hits  = 0;
        test_name   = "reset";
        lfsr_state  = 16'd27;
        fill_memories();
        alternate_palette_bits(3);  // Tile row of line 52
        load_palette();

        repeat (RESET_CYCLES) @(negedge clk);
        reset     = 1'b0;
        test_name = "idle after reset";
        repeat (IDLE_CYCLES) drive_timing(1'b0, 1'b0, 0, 0);

        run_vblank();
        pixel_check = 1'b1;
        run_line(0, "line 0");
        run_line(17, "line 17");
        run_line(35, "line 35");

        lower_hits = 0;
        upper_hits = 0;
        run_line(52, "alternating palette line 52");
        check("line 52 uses lower palette half", 1, 32'(lower_hits > 0));
        check("line 52 uses upper palette half", 1, 32'(upper_hits > 0));

        // Second frame with a fresh palette
        load_palette();
        run_vblank();
        run_line(0, "new palette line 0");
        run_line(35, "new palette line 35");

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("Timeout: the test sequence did not finish in time, errors so far: %0d",
                 errors);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// File: vlog.f
hw/ppu_pkg.sv
hw/palette_cache.sv
hw/tile_line_fetch.sv
hw/line_buffer.sv
hw/background_shifter.sv
hw/ppu_top.sv
verif/ppu_mem_model.sv
verif/tb_ppu_top.sv
